//--- verilog/sm3_expnd_cfg.svh
`ifndef SM3_EXPND_CFG_SVH
`define SM3_EXPND_CFG_SVH

//////////////////////////////////////////////////////////////
// datapath sizes
//////////////////////////////////////////////////////////////

`define SM3_WORD_W      32  // message word width
`define SM3_BLK_WORDS   16  // original words per 512-bit block
`define SM3_PAIR_NUM    64  // W/W' pairs emitted per block

// W'j = Wj ^ Wj+4, so the wj tap sits this far behind the buffer head
`define SM3_WJJ_DIST    4

//////////////////////////////////////////////////////////////
// rotation amounts
//////////////////////////////////////////////////////////////

`define SM3_ROT_P1_A    15  // P1 first rotate
`define SM3_ROT_P1_B    23  // P1 second rotate
`define SM3_ROT_W3      15  // applied to Wj-3
`define SM3_ROT_W13     7   // applied to Wj-13

`endif

//--- verilog/sm3_expnd_pkg.sv
`include "sm3_expnd_cfg.svh"

package sm3_expnd_pkg;

    //////////////////////////////////////////////////////////////
    // basic word
    //////////////////////////////////////////////////////////////

    typedef logic [`SM3_WORD_W-1:0] word_t;

    //////////////////////////////////////////////////////////////
    // stream types
    //////////////////////////////////////////////////////////////

    // one padded input word plus last-block mark
    typedef struct packed {
        word_t data;
        logic  last;
    } pad_beat_t;

    // one output pair
    typedef struct packed {
        word_t wj;   // Wj
        word_t wjj;  // W'j = Wj ^ Wj+4
    } expnd_pair_t;

    //////////////////////////////////////////////////////////////
    // control into the word buffer
    //////////////////////////////////////////////////////////////

    typedef struct packed {
        logic shift;    // move one place toward index 0
        logic sel_exp;  // index 15 takes the expanded word, else input
    } buff_ctl_t;

endpackage

//--- verilog/sm3_expnd_ctrl.sv
`include "sm3_expnd_cfg.svh"

module sm3_expnd_ctrl
    import sm3_expnd_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      pad_vld_i,
    input  logic      pad_last_i,
    output logic      pad_rdy_o,

    output buff_ctl_t buff_ctl_o,

    output logic      pair_vld_o,
    output logic      pair_lst_o
);

    //////////////////////////////////////////////////////////////
    // block sequencing constants
    //////////////////////////////////////////////////////////////

    // words 0..4 fill the buffer before the first pair shows up
    localparam logic [3:0] LOAD_LAST = 4'(`SM3_WJJ_DIST);
    localparam logic [3:0] WORD_LAST = 4'(`SM3_BLK_WORDS - 1);

    // pairs already sent while loading: 16 - 4 - 1 = 11
    localparam int         LOAD_PAIRS = `SM3_BLK_WORDS - `SM3_WJJ_DIST - 1;

    // 53 expand cycles, counted 0..52
    localparam logic [5:0] RND_LAST = 6'(`SM3_PAIR_NUM - LOAD_PAIRS - 1);

    typedef enum logic [1:0] {
        ST_IDLE,      // waiting for word 0
        ST_LOAD,      // words 1..4, no output yet
        ST_LOAD_OUT,  // words 5..15, one pair per accepted word
        ST_EXPAND     // W16..W67, one pair per cycle
    } state_e;

    state_e     state;
    state_e     nxt_state;

    logic [3:0] word_cnt;  // accepted words in this block, wraps at 16
    logic [5:0] rnd_cnt;   // expand round
    logic       last_flg;  // block carries the last mark

    logic       accept;
    logic       in_expand;
    logic       rnd_done;

    //////////////////////////////////////////////////////////////
    // handshake and decode
    //////////////////////////////////////////////////////////////

    assign in_expand = (state == ST_EXPAND);
    assign rnd_done  = in_expand && (rnd_cnt == RND_LAST);

    // ready is low only while the buffer is expanding
    assign pad_rdy_o = !in_expand;
    assign accept    = pad_vld_i && pad_rdy_o;

    //////////////////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////////////////

    always_comb begin
        nxt_state = state;
        case (state)
            ST_IDLE: begin
                if (accept)
                    nxt_state = ST_LOAD;
            end
            ST_LOAD: begin
                if (accept && word_cnt == LOAD_LAST)
                    nxt_state = ST_LOAD_OUT;  // word 4 in, pairs start next word
            end
            ST_LOAD_OUT: begin
                if (accept && word_cnt == WORD_LAST)
                    nxt_state = ST_EXPAND;
            end
            ST_EXPAND: begin
                if (rnd_done)
                    nxt_state = ST_IDLE;
            end
            default: nxt_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= nxt_state;
        end
    end

    //////////////////////////////////////////////////////////////
    // counters
    //////////////////////////////////////////////////////////////

    // wraps back to zero after word 15
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt <= 4'd0;
        end else if (accept) begin
            word_cnt <= word_cnt + 4'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rnd_cnt <= 6'd0;
        end else if (rnd_done) begin
            rnd_cnt <= 6'd0;
        end else if (in_expand) begin
            rnd_cnt <= rnd_cnt + 6'd1;
        end
    end

    //////////////////////////////////////////////////////////////
    // last-block flag
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_flg <= 1'b0;
        end else if (accept && pad_last_i) begin
            last_flg <= 1'b1;
        end else if (pair_lst_o) begin
            last_flg <= 1'b0;  // consumed by pair 63
        end
    end

    //////////////////////////////////////////////////////////////
    // buffer control and output flags
    //////////////////////////////////////////////////////////////

    always_comb begin
        buff_ctl_o.shift   = accept || in_expand;
        buff_ctl_o.sel_exp = in_expand;
    end

    assign pair_vld_o = (state == ST_LOAD_OUT && accept) || in_expand;
    assign pair_lst_o = last_flg && rnd_done;  // only with pair 63

    //////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////

    // buffer moves without an input word only once a full block is in
    a_shift_no_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        (buff_ctl_o.shift && !pad_rdy_o) |-> (word_cnt == 4'd0)
    );

    a_rnd_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        rnd_cnt <= RND_LAST
    );

    a_lst_with_vld: assert property (
        @(posedge clk) disable iff (!rst_n)
        pair_lst_o |-> pair_vld_o
    );

endmodule

//--- verilog/sm3_word_buff.sv
`include "sm3_expnd_cfg.svh"

module sm3_word_buff
    import sm3_expnd_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  word_t       word_i,
    input  buff_ctl_t   buff_ctl_i,

    output expnd_pair_t pair_o
);

    //////////////////////////////////////////////////////////////
    // buffer taps
    //////////////////////////////////////////////////////////////

    localparam int HEAD = `SM3_BLK_WORDS - 1;  // newest word

    // index 0 holds Wj-16 when W(j) is being generated
    localparam int TAP_W16 = 0;
    localparam int TAP_W13 = `SM3_BLK_WORDS - 13;  // 3
    localparam int TAP_W9  = `SM3_BLK_WORDS - 9;   // 7
    localparam int TAP_W6  = `SM3_BLK_WORDS - 6;   // 10
    localparam int TAP_W3  = `SM3_BLK_WORDS - 3;   // 13

    // output tap, W'j partner sits at the head
    localparam int TAP_OUT = HEAD - `SM3_WJJ_DIST;  // 11

    //////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////

    function automatic word_t rotl(input word_t x, input int unsigned n);
        return (x << n) | (x >> (`SM3_WORD_W - n));
    endfunction

    function automatic word_t p1(input word_t x);
        return x ^ rotl(x, `SM3_ROT_P1_A) ^ rotl(x, `SM3_ROT_P1_B);
    endfunction

    word_t word_buff [`SM3_BLK_WORDS];

    word_t exp_pre;   // argument of P1
    word_t exp_word;  // next Wj
    word_t new_push;  // word entering at the head

    //////////////////////////////////////////////////////////////
    // expansion network
    //////////////////////////////////////////////////////////////

    assign exp_pre = word_buff[TAP_W16]
                   ^ word_buff[TAP_W9]
                   ^ rotl(word_buff[TAP_W3], `SM3_ROT_W3);

    assign exp_word = p1(exp_pre)
                    ^ rotl(word_buff[TAP_W13], `SM3_ROT_W13)
                    ^ word_buff[TAP_W6];

    // original words while loading, expanded ones afterwards
    assign new_push = buff_ctl_i.sel_exp ? exp_word : word_i;

    //////////////////////////////////////////////////////////////
    // 16-word shift buffer
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `SM3_BLK_WORDS; i++) begin
                word_buff[i] <= '0;
            end
        end else if (buff_ctl_i.shift) begin
            // w0 <- w1 ... w14 <- w15
            for (int i = 0; i < HEAD; i++) begin
                word_buff[i] <= word_buff[i+1];
            end
            word_buff[HEAD] <= new_push;
        end
    end

    //////////////////////////////////////////////////////////////
    // output taps
    //////////////////////////////////////////////////////////////

    assign pair_o.wj  = word_buff[TAP_OUT];
    assign pair_o.wjj = word_buff[TAP_OUT] ^ word_buff[HEAD];

    // expanded words only ever enter on a shift
    a_sel_needs_shift: assert property (
        @(posedge clk) disable iff (!rst_n)
        buff_ctl_i.sel_exp |-> buff_ctl_i.shift
    );

endmodule

//--- verilog/sm3_expnd_top.sv
`include "sm3_expnd_cfg.svh"

module sm3_expnd_top
    import sm3_expnd_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // padded message words in
    input  pad_beat_t   pad_i,
    input  logic        pad_vld_i,
    output logic        pad_rdy_o,

    // W/W' pairs out, no back-pressure
    output expnd_pair_t pair_o,
    output logic        pair_vld_o,
    output logic        pair_lst_o
);

    //////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////

    buff_ctl_t buff_ctl;

    sm3_expnd_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .pad_vld_i  (pad_vld_i),
        .pad_last_i (pad_i.last),
        .pad_rdy_o  (pad_rdy_o),
        .buff_ctl_o (buff_ctl),
        .pair_vld_o (pair_vld_o),
        .pair_lst_o (pair_lst_o)
    );

    //////////////////////////////////////////////////////////////
    // word buffer and expansion
    //////////////////////////////////////////////////////////////

    sm3_word_buff u_buff (
        .clk        (clk),
        .rst_n      (rst_n),
        .word_i     (pad_i.data),  // data only, last goes to control
        .buff_ctl_i (buff_ctl),
        .pair_o     (pair_o)
    );

endmodule

//--- dv/sm3_expnd_chk.sv
`include "sm3_expnd_cfg.svh"

module sm3_expnd_chk
    import sm3_expnd_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // top-level ports, observed only
    input  pad_beat_t   pad_i,
    input  logic        pad_vld_i,
    input  logic        pad_rdy_i,
    input  expnd_pair_t pair_i,
    input  logic        pair_vld_i,
    input  logic        pair_lst_i,

    input  logic        done_i,     // end of run, print the summary
    output int          err_cnt_o,
    output int          blk_cnt_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BLK       = `SM3_BLK_WORDS;
    localparam int PAIRS     = `SM3_PAIR_NUM;
    localparam int DIST      = `SM3_WJJ_DIST;
    localparam int FIRST_OUT = DIST + 1;  // accepted word that brings out pair 0

    word_t w_ref [PAIRS + DIST];  // W0..W67 of the current block

    int    wcnt      = 0;  // words captured, BLK means expanding
    int    pcnt      = 0;  // pairs expected so far
    int    data_errs = 0;
    int    ctl_errs  = 0;
    int    blk_cnt   = 0;
    logic  lst_mark  = 1'b0;
    logic  reported  = 1'b0;
    logic  accept;
    logic  expanding;
    logic  exp_vld;
    logic  exp_lst;

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic word_t rot_left(input word_t x, input int n);
        logic [2*`SM3_WORD_W-1:0] dbl;
        dbl = {x, x} >> (`SM3_WORD_W - n);
        return dbl[`SM3_WORD_W-1:0];
    endfunction

    function automatic word_t perm_p1(input word_t x);
        return x ^ rot_left(x, `SM3_ROT_P1_A) ^ rot_left(x, `SM3_ROT_P1_B);
    endfunction

    // fills W16..W67 once all 16 words are in
    task automatic expand_ref();
        word_t t;
        for (int j = BLK; j < PAIRS + DIST; j++) begin
            t = w_ref[j-16] ^ w_ref[j-9] ^ rot_left(w_ref[j-3], `SM3_ROT_W3);
            w_ref[j] = perm_p1(t) ^ rot_left(w_ref[j-13], `SM3_ROT_W13) ^ w_ref[j-6];
        end
    endtask

    ////////////////////////////////////////////////////////////
    // per-cycle compare, mid-cycle when everything is settled
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst_n) begin
            wcnt     = 0;
            pcnt     = 0;
            lst_mark = 1'b0;
        end else begin
            accept    = pad_vld_i && pad_rdy_i;
            expanding = (wcnt == BLK);
            exp_vld   = expanding || (accept && wcnt >= FIRST_OUT);
            exp_lst   = expanding && lst_mark && (pcnt == PAIRS - 1);

            if (pad_rdy_i != !expanding) begin
                ctl_errs++;
                $display("mismatch at %0t: pad_rdy_o %b, expected %b (word %0d, pair %0d)",
                         $time, pad_rdy_i, !expanding, wcnt, pcnt);
            end
            if (pair_vld_i != exp_vld) begin
                ctl_errs++;
                $display("mismatch at %0t: pair_vld_o %b, expected %b (word %0d, pair %0d)",
                         $time, pair_vld_i, exp_vld, wcnt, pcnt);
            end
            if (pair_lst_i != exp_lst) begin
                ctl_errs++;
                $display("mismatch at %0t: pair_lst_o %b, expected %b (block %0d, pair %0d)",
                         $time, pair_lst_i, exp_lst, blk_cnt, pcnt);
            end

            if (exp_vld && pair_vld_i) begin
                if (pair_i.wj !== w_ref[pcnt] ||
                    pair_i.wjj !== (w_ref[pcnt] ^ w_ref[pcnt+DIST])) begin
                    data_errs++;
                    $display("mismatch at %0t: block %0d pair %0d got %h/%h, expected %h/%h",
                             $time, blk_cnt, pcnt, pair_i.wj, pair_i.wjj,
                             w_ref[pcnt], w_ref[pcnt] ^ w_ref[pcnt+DIST]);
                end
            end

            if (exp_vld)
                pcnt++;  // model timing, not the DUT flag
            if (pcnt == PAIRS) begin
                blk_cnt++;
                wcnt     = 0;
                pcnt     = 0;
                lst_mark = 1'b0;
            end else if (accept && !expanding) begin
                w_ref[wcnt] = pad_i.data;
                lst_mark    = lst_mark | pad_i.last;
                wcnt++;
                if (wcnt == BLK)
                    expand_ref();
            end
        end

        if (done_i && !reported) begin
            reported = 1'b1;
            if (wcnt != 0 || pcnt != 0) begin
                ctl_errs++;
                $display("block left unfinished at end of run: %0d words in, %0d pairs out",
                         wcnt, pcnt);
            end
            $display("checker: %0d data errors, %0d control errors, %0d blocks checked",
                     data_errs, ctl_errs, blk_cnt);
        end
    end

    assign err_cnt_o = data_errs + ctl_errs;
    assign blk_cnt_o = blk_cnt;

endmodule

//--- dv/tb_sm3_expnd.sv
`include "sm3_expnd_cfg.svh"

module tb_sm3_expnd
    import sm3_expnd_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [31:0] gaps;  // 2 bits per word, valid-low cycles before it
        logic        last;  // last mark on word 15, pair 63 must carry it
    } stim_t;

    localparam int          N_ENTRY   = 6;
    localparam int          BLK       = `SM3_BLK_WORDS;
    localparam int          RDY_TMO   = 100;
    localparam int          DRAIN_TMO = 200;
    localparam logic [31:0] LFSR_SEED = 32'd93;
    localparam logic [31:0] LFSR_POLY = 32'h8020_0003;  // x^32+x^22+x^2+x+1

    localparam stim_t STIM_TBL [N_ENTRY] = '{
        '{32'h0000_0000, 1'b0},  // back to back
        '{32'h1B6C_E4A9, 1'b1},  // mixed bubbles
        '{32'h0000_0000, 1'b0},  // right after a last block
        '{32'hFFFF_FFFF, 1'b0},  // three bubbles before every word
        '{32'h0000_0003, 1'b1},
        '{32'h8000_0000, 1'b1}   // two last blocks in a row
    };

    logic        clk = 1'b0;
    logic        rst_n;
    pad_beat_t   pad_i;
    logic        pad_vld_i;
    logic        pad_rdy_o;
    expnd_pair_t pair_o;
    logic        pair_vld_o;
    logic        pair_lst_o;
    logic        chk_done;
    int          chk_errs;
    int          blk_cnt;
    logic [31:0] lfsr;
    logic        timed_out;

    always #5 clk = ~clk;

    sm3_expnd_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .pad_i      (pad_i),
        .pad_vld_i  (pad_vld_i),
        .pad_rdy_o  (pad_rdy_o),
        .pair_o     (pair_o),
        .pair_vld_o (pair_vld_o),
        .pair_lst_o (pair_lst_o)
    );

    sm3_expnd_chk u_chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .pad_i      (pad_i),
        .pad_vld_i  (pad_vld_i),
        .pad_rdy_i  (pad_rdy_o),
        .pair_i     (pair_o),
        .pair_vld_i (pair_vld_o),
        .pair_lst_i (pair_lst_o),
        .done_i     (chk_done),
        .err_cnt_o  (chk_errs),
        .blk_cnt_o  (blk_cnt)
    );

    ////////////////////////////////////////////////////////////
    // word source
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ LFSR_POLY;
        return n;
    endfunction

    task automatic draw_word(output word_t w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            w    = {w[30:0], lfsr[0]};  // one step per bit
            lfsr = lfsr_next(lfsr);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // input driver
    ////////////////////////////////////////////////////////////

    task automatic send_word(input word_t data, input logic last, input int gap);
        int waited;
        for (int i = 0; i < gap; i++) begin
            pad_vld_i <= 1'b0;
            @(posedge clk);
        end
        pad_i.data <= data;
        pad_i.last <= last;
        pad_vld_i  <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (!pad_rdy_o && waited < RDY_TMO) begin
            waited++;
            @(negedge clk);
        end
        if (!pad_rdy_o) begin
            timed_out = 1'b1;
            $display("timeout: pad_rdy_o stayed low for %0d cycles", RDY_TMO);
        end
        @(posedge clk);  // transfer edge
    endtask

    task automatic send_block(input stim_t s);
        word_t data;
        for (int k = 0; k < BLK; k++) begin
            if (!timed_out) begin
                draw_word(data);
                send_word(data, s.last && (k == BLK - 1), int'(s.gaps[2*k +: 2]));
            end
        end
    endtask

    // all blocks must come out of the checker
    task automatic wait_drain();
        int waited;
        waited = 0;
        @(posedge clk);
        while (blk_cnt != N_ENTRY && waited < DRAIN_TMO) begin
            waited++;
            @(posedge clk);
        end
        if (blk_cnt != N_ENTRY) begin
            timed_out = 1'b1;
            $display("timeout: only %0d of %0d blocks came out", blk_cnt, N_ENTRY);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        pad_i     = '0;
        pad_vld_i = 1'b0;
        chk_done  = 1'b0;
        lfsr      = LFSR_SEED;
        timed_out = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);  // idle, ready high and no pairs

        for (int e = 0; e < N_ENTRY; e++) begin
            if (!timed_out)
                send_block(STIM_TBL[e]);
        end
        pad_vld_i <= 1'b0;
        if (!timed_out)
            wait_drain();

        chk_done <= 1'b1;
        repeat (2) @(posedge clk);
        if (timed_out || chk_errs != 0) begin
            $display("SIMULATION FAILED");
        end else begin
            $display("SIMULATION PASSED");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+verilog
verilog/sm3_expnd_pkg.sv
verilog/sm3_expnd_ctrl.sv
verilog/sm3_word_buff.sv
verilog/sm3_expnd_top.sv
dv/sm3_expnd_chk.sv
dv/tb_sm3_expnd.sv

//--- run.sh
#!/bin/sh
# compile and run the SM3 expansion testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_sm3_expnd -f files.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi
exit 0
